// ==== common/stopwatchPkg.sv ====
package stopwatchPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Shared constants
    ////////////////////////////////////////////////////////////////////////////

    // Highest value of a minute or second unit
    localparam logic [5:0] maxUnitValue = 6'd59;

    // Number of display digits
    localparam int digitCount = 4;

    // Hardware divider lengths, in adjclk cycles
    localparam int defaultTickDivisor    = 50_000_000;
    localparam int defaultScanDivisor    = 100_000;
    localparam int defaultDebounceCycles = 1_000_000;

    // Active-low patterns in gfedcba order, codes 10 to 15 blank
    localparam logic [6:0] segmentTable [16] = '{
        7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
        7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
        7'b0000000, 7'b0010000, 7'b1111111, 7'b1111111,
        7'b1111111, 7'b1111111, 7'b1111111, 7'b1111111
    };

    ////////////////////////////////////////////////////////////////////////////
    // Shared types
    ////////////////////////////////////////////////////////////////////////////

    // Stopwatch time, both units 0 to 59
    typedef struct packed {
        logic [5:0] minutes;
        logic [5:0] seconds;
    } timeValue;

    // Synchronized mode switches
    typedef struct packed {
        logic adj;
        logic sel;
    } switchState;

    // One segment pattern per digit position
    typedef struct packed {
        logic [6:0] minTens;
        logic [6:0] minOnes;
        logic [6:0] secTens;
        logic [6:0] secOnes;
    } segmentSet;

endpackage

// ==== display/digitEncoder.sv ====
`timescale 1ns/10ps

module digitEncoder import stopwatchPkg::*; (
    input  timeValue  currentTime,
    output segmentSet patterns
);

    // Tens digit of a 0 to 59 value
    function automatic logic [3:0] tensOf(input logic [5:0] unitValue);
        logic [5:0] quotient;
        quotient = unitValue / 6'd10;
        return quotient[3:0];
    endfunction

    // Ones digit of a 0 to 59 value
    function automatic logic [3:0] onesOf(input logic [5:0] unitValue);
        logic [5:0] remainder;
        remainder = unitValue % 6'd10;
        return remainder[3:0];
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Digit lookup
    ////////////////////////////////////////////////////////////////////////////
    always_comb
    begin
        // Minutes on the left pair
        patterns.minTens = segmentTable[tensOf(currentTime.minutes)];
        patterns.minOnes = segmentTable[onesOf(currentTime.minutes)];
        // Seconds on the right pair
        patterns.secTens = segmentTable[tensOf(currentTime.seconds)];
        patterns.secOnes = segmentTable[onesOf(currentTime.seconds)];
    end

endmodule

// ==== display/displayScanner.sv ====
`timescale 1ns/10ps

module displayScanner import stopwatchPkg::*; (
    input  logic       adjclk,
    input  logic       btn0_val,
    input  logic       scanTick,
    input  segmentSet  patterns,
    output logic [3:0] anodes,
    output logic [6:0] segments
);

    // 0 secOnes, 1 secTens, 2 minOnes, 3 minTens
    logic [1:0] digitIndex;
    logic [6:0] selectedPattern;

    ////////////////////////////////////////////////////////////////////////////
    // Digit index
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge adjclk or posedge btn0_val)
    begin
        if (btn0_val)
        begin
            digitIndex <= 2'd0;
        end
        else if (scanTick)
        begin
            if (digitIndex == 2'(digitCount - 1))
            begin
                digitIndex <= 2'd0;
            end
            else
            begin
                digitIndex <= digitIndex + 2'd1;
            end
        end
    end

    // Pattern for the active position
    always_comb
    begin
        case (digitIndex)
            2'd0:    selectedPattern = patterns.secOnes;
            2'd1:    selectedPattern = patterns.secTens;
            2'd2:    selectedPattern = patterns.minOnes;
            default: selectedPattern = patterns.minTens;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output registers
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge adjclk or posedge btn0_val)
    begin
        if (btn0_val)
        begin
            // Rightmost digit enabled, segments blank
            anodes   <= 4'b1110;
            segments <= 7'b1111111;
        end
        else
        begin
            // One anode low, common-anode display
            anodes   <= ~(4'b0001 << digitIndex);
            segments <= selectedPattern;
        end
    end

endmodule

// ==== hdl/buttonConditioner.sv ====
`timescale 1ns/10ps

module buttonConditioner import stopwatchPkg::*; #(
    parameter int debounceCycles = 1_000_000
) (
    input  logic       adjclk,
    input  logic       btn0_val,
    input  logic       btn1_val,
    input  logic       adj,
    input  logic       sel,
    output switchState switches,
    output logic       pauseToggle
);

    // Two-flop synchronizer, bits are {btn1_val, adj, sel}
    logic [2:0] syncFirst;
    logic [2:0] syncSecond;
    // Debounced pause level
    logic pauseLevel;
    // Cycles the synchronized button has differed from pauseLevel
    logic [$clog2(debounceCycles+1)-1:0] stableCount;
    logic pauseSync;

    assign pauseSync = syncSecond[2];

    // Mode switches only need synchronizing
    assign switches = '{adj: syncSecond[1], sel: syncSecond[0]};

    always_ff @(posedge adjclk or posedge btn0_val)
    begin
        if (btn0_val)
        begin
            syncFirst  <= '0;
            syncSecond <= '0;
        end
        else
        begin
            syncFirst  <= {btn1_val, adj, sel};
            syncSecond <= syncFirst;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pause debounce
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge adjclk or posedge btn0_val)
    begin
        if (btn0_val)
        begin
            pauseLevel  <= 1'b0;
            stableCount <= '0;
            pauseToggle <= 1'b0;
        end
        else
        begin
            pauseToggle <= 1'b0;
            if (pauseSync == pauseLevel)
            begin
                // Bounce back to the old level restarts the wait
                stableCount <= '0;
            end
            else if (stableCount == $bits(stableCount)'(debounceCycles - 1))
            begin
                // New level held long enough, accept it
                pauseLevel  <= pauseSync;
                stableCount <= '0;
                // Only a press toggles, a release just rearms
                pauseToggle <= pauseSync;
            end
            else
            begin
                stableCount <= stableCount + 1'b1;
            end
        end
    end

endmodule

// ==== hdl/stopwatchTop.sv ====
`timescale 1ns/10ps

module stopwatchTop import stopwatchPkg::*; #(
    parameter int tickDivisor    = defaultTickDivisor,
    parameter int scanDivisor    = defaultScanDivisor,
    parameter int debounceCycles = defaultDebounceCycles
) (
    input  logic       adjclk,
    input  logic       btn0_val,
    input  logic       btn1_val,
    input  logic       adj,
    input  logic       sel,
    output timeValue   currentTime,
    output logic [3:0] anodes,
    output logic [6:0] segments
);

    // Strobes
    logic adjustTick;
    logic countTick;
    logic scanTick;
    logic pauseToggle;

    // Struct links
    switchState switches;
    segmentSet  patterns;

    ////////////////////////////////////////////////////////////////////////////
    // Timing and inputs
    ////////////////////////////////////////////////////////////////////////////
    tickGenerator #(
        .tickDivisor (tickDivisor),
        .scanDivisor (scanDivisor)
    ) tickGen0 (
        .adjclk     (adjclk),
        .btn0_val   (btn0_val),
        .adjustTick (adjustTick),
        .countTick  (countTick),
        .scanTick   (scanTick)
    );

    buttonConditioner #(
        .debounceCycles (debounceCycles)
    ) buttons0 (
        .adjclk      (adjclk),
        .btn0_val    (btn0_val),
        .btn1_val    (btn1_val),
        .adj         (adj),
        .sel         (sel),
        .switches    (switches),
        .pauseToggle (pauseToggle)
    );

    // Minute and second registers
    timeCounter counter0 (
        .adjclk      (adjclk),
        .btn0_val    (btn0_val),
        .countTick   (countTick),
        .adjustTick  (adjustTick),
        .pauseToggle (pauseToggle),
        .switches    (switches),
        .currentTime (currentTime)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Display path
    ////////////////////////////////////////////////////////////////////////////
    digitEncoder encoder0 (
        .currentTime (currentTime),
        .patterns    (patterns)
    );

    displayScanner scanner0 (
        .adjclk   (adjclk),
        .btn0_val (btn0_val),
        .scanTick (scanTick),
        .patterns (patterns),
        .anodes   (anodes),
        .segments (segments)
    );

endmodule

// ==== hdl/tickGenerator.sv ====
`timescale 1ns/10ps

module tickGenerator #(
    parameter int tickDivisor = 50_000_000,
    parameter int scanDivisor = 100_000
) (
    input  logic adjclk,
    input  logic btn0_val,
    output logic adjustTick,
    output logic countTick,
    output logic scanTick
);

    // Free-running down-counters
    logic [$clog2(tickDivisor)-1:0] adjustCount;
    logic [$clog2(scanDivisor)-1:0] scanCount;
    // Alternates on each adjust strobe
    logic countPhase;

    ////////////////////////////////////////////////////////////////////////////
    // Adjust and count strobes
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge adjclk or posedge btn0_val)
    begin
        if (btn0_val)
        begin
            adjustCount <= $bits(adjustCount)'(tickDivisor - 1);
            countPhase  <= 1'b0;
            adjustTick  <= 1'b0;
            countTick   <= 1'b0;
        end
        else
        begin
            adjustTick <= (adjustCount == '0);
            // Every second adjust strobe is a count strobe
            countTick  <= (adjustCount == '0) && countPhase;
            if (adjustCount == '0)
            begin
                adjustCount <= $bits(adjustCount)'(tickDivisor - 1);
                countPhase  <= ~countPhase;
            end
            else
            begin
                adjustCount <= adjustCount - 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Display scan strobe
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge adjclk or posedge btn0_val)
    begin
        if (btn0_val)
        begin
            scanCount <= $bits(scanCount)'(scanDivisor - 1);
            scanTick  <= 1'b0;
        end
        else
        begin
            scanTick <= (scanCount == '0);
            if (scanCount == '0)
            begin
                scanCount <= $bits(scanCount)'(scanDivisor - 1);
            end
            else
            begin
                scanCount <= scanCount - 1'b1;
            end
        end
    end

endmodule

// ==== hdl/timeCounter.sv ====
`timescale 1ns/10ps

module timeCounter import stopwatchPkg::*; (
    input  logic       adjclk,
    input  logic       btn0_val,
    input  logic       countTick,
    input  logic       adjustTick,
    input  logic       pauseToggle,
    input  switchState switches,
    output timeValue   currentTime
);

    // Paused flag
    logic paused;
    // Pause state with this cycle's toggle already applied
    logic pausedNow;

    ////////////////////////////////////////////////////////////////////////////
    // Unit step, 59 wraps to 0
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [5:0] stepUnit(input logic [5:0] unitValue);
        if (unitValue >= maxUnitValue)
        begin
            return 6'd0;
        end
        return unitValue + 6'd1;
    endfunction

    // Toggle takes effect before any tick in the same cycle
    assign pausedNow = paused ^ pauseToggle;

    always_ff @(posedge adjclk or posedge btn0_val)
    begin
        if (btn0_val)
        begin
            paused      <= 1'b0;
            currentTime <= '0;
        end
        else
        begin
            paused <= pausedNow;
            if (!pausedNow)
            begin
                if (!switches.adj)
                begin
                    // Normal counting with carry into minutes
                    if (countTick)
                    begin
                        if (currentTime.seconds >= maxUnitValue)
                        begin
                            currentTime.seconds <= 6'd0;
                            currentTime.minutes <= stepUnit(currentTime.minutes);
                        end
                        else
                        begin
                            currentTime.seconds <= currentTime.seconds + 6'd1;
                        end
                    end
                end
                else if (adjustTick)
                begin
                    // Adjust one unit, no carry
                    if (switches.sel)
                    begin
                        currentTime.seconds <= stepUnit(currentTime.seconds);
                    end
                    else
                    begin
                        currentTime.minutes <= stepUnit(currentTime.minutes);
                    end
                end
            end
        end
    end

endmodule

// ==== runSim.sh ====
#!/bin/sh
# Build and run the stopwatch testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module stopwatchTb \
    -f stopwatch.f -o stopwatchSim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/stopwatchSim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0

// ==== stopwatch.f ====
common/stopwatchPkg.sv
hdl/tickGenerator.sv
hdl/buttonConditioner.sv
hdl/timeCounter.sv
display/digitEncoder.sv
display/displayScanner.sv
hdl/stopwatchTop.sv
test/clockGen.sv
test/stopwatchTb.sv

// ==== test/clockGen.sv ====
`timescale 1ns/10ps

module clockGen #(
    parameter int halfPeriod = 50
) (
    output logic adjclk
);

    // Free-running testbench clock, 100 ns period
    initial
    begin
        adjclk = 1'b0;
    end

    always #(halfPeriod) adjclk = ~adjclk;

endmodule

// ==== test/stopwatchTb.sv ====
`timescale 1ns/10ps

module stopwatchTb import stopwatchPkg::*; ();

    // Cycle limit for any single wait
    localparam int changeLimit = 40;

    logic       adjclk;
    logic       btn0_val;
    logic       btn1_val;
    logic       adj;
    logic       sel;
    timeValue   currentTime;
    logic [3:0] anodes;
    logic [6:0] segments;
    integer     seed;

    clockGen clock0 (.adjclk(adjclk));

    // Short dividers so the whole run stays small
    stopwatchTop #(
        .tickDivisor    (4),
        .scanDivisor    (3),
        .debounceCycles (5)
    ) dut0 (
        .adjclk      (adjclk),
        .btn0_val    (btn0_val),
        .btn1_val    (btn1_val),
        .adj         (adj),
        .sel         (sel),
        .currentTime (currentTime),
        .anodes      (anodes),
        .segments    (segments)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Reference rules and helpers
    ////////////////////////////////////////////////////////////////////////////

    // One unit step, 59 back to 0
    function automatic logic [5:0] unitNext(input logic [5:0] unitValue);
        return (unitValue == maxUnitValue) ? 6'd0 : unitValue + 6'd1;
    endfunction

    // Normal count with carry into minutes
    function automatic timeValue countNext(input timeValue oldTime);
        timeValue nextTime;
        nextTime = oldTime;
        nextTime.seconds = unitNext(oldTime.seconds);
        if (oldTime.seconds == maxUnitValue)
        begin
            nextTime.minutes = unitNext(oldTime.minutes);
        end
        return nextTime;
    endfunction

    // Index of the single low anode, -1 unless exactly one is low
    function automatic int lowAnode(input logic [3:0] pattern);
        int found;
        int zeros;
        int i;
        found = -1;
        zeros = 0;
        for (i = 0; i < digitCount; i++)
        begin
            if (!pattern[i])
            begin
                zeros++;
                found = i;
            end
        end
        return (zeros == 1) ? found : -1;
    endfunction

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("ERR %s expected %0h actual %0h", testName, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Mismatch in %s", testName);
        end
    endtask

    task automatic reportTimeout(input string what);
        $display("Timed out while waiting for %s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Wait limit reached");
    endtask

    // Returns on the falling edge where currentTime first differs
    task automatic waitTimeChange(input string what, output timeValue newTime);
        timeValue startTime;
        int cycles;
        startTime = currentTime;
        cycles = 0;
        @(negedge adjclk);
        while (currentTime == startTime && cycles < changeLimit)
        begin
            @(negedge adjclk);
            cycles++;
        end
        if (currentTime == startTime)
        begin
            reportTimeout(what);
        end
        newTime = currentTime;
    endtask

    task automatic applyReset();
        btn0_val = 1'b1;
        repeat (8) @(negedge adjclk);
        btn0_val = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic testReset();
        checkValue("reset time", 32'd0, 32'(currentTime));
        checkValue("reset anodes", 32'd1, 32'(lowAnode(anodes) >= 0));
    endtask

    task automatic testCounting();
        timeValue prevTime;
        timeValue newTime;
        prevTime = currentTime;
        // 130 steps pass 00:59 and 01:59
        repeat (130)
        begin
            waitTimeChange("a count step", newTime);
            checkValue("counting", 32'(countNext(prevTime)), 32'(newTime));
            prevTime = newTime;
        end
    endtask

    task automatic testAdjust();
        timeValue prevTime;
        timeValue newTime;
        timeValue expected;
        int steps;
        logic sawWrap;
        // Switch right after a change, well clear of the next strobe
        adj = 1'b1;
        sel = 1'b1;
        prevTime = currentTime;
        repeat (60)
        begin
            waitTimeChange("a seconds adjust step", newTime);
            expected = prevTime;
            expected.seconds = unitNext(prevTime.seconds);
            checkValue("adjust seconds", 32'(expected), 32'(newTime));
            prevTime = newTime;
        end
        sel = 1'b0;
        steps = 0;
        sawWrap = 1'b0;
        while (!sawWrap && steps < 61)
        begin
            waitTimeChange("a minutes adjust step", newTime);
            expected = prevTime;
            expected.minutes = unitNext(prevTime.minutes);
            checkValue("adjust minutes", 32'(expected), 32'(newTime));
            sawWrap = (prevTime.minutes == maxUnitValue);
            prevTime = newTime;
            steps++;
        end
        checkValue("adjust minute wrap", 32'd1, 32'(sawWrap));
    endtask

    task automatic testMinuteWrap();
        timeValue newTime;
        int steps;
        // Minutes up to 59, then seconds up to 58
        steps = 0;
        while (currentTime.minutes != maxUnitValue && steps < 70)
        begin
            waitTimeChange("minutes to reach 59", newTime);
            steps++;
        end
        sel = 1'b1;
        steps = 0;
        while (currentTime.seconds != 6'd58 && steps < 70)
        begin
            waitTimeChange("seconds to reach 58", newTime);
            steps++;
        end
        checkValue("wrap setup", 32'({6'd59, 6'd58}), 32'(currentTime));
        adj = 1'b0;
        waitTimeChange("59:59", newTime);
        checkValue("wrap to 59:59", 32'({6'd59, 6'd59}), 32'(newTime));
        waitTimeChange("00:00", newTime);
        checkValue("wrap to 00:00", 32'd0, 32'(newTime));
    endtask

    task automatic testPause();
        timeValue lastTime;
        timeValue newTime;
        int stableRun;
        int cycles;
        int steps;
        int i;
        // Minutes to 17 so the held time shows four different digits
        adj = 1'b1;
        sel = 1'b0;
        steps = 0;
        while (currentTime.minutes != 6'd17 && steps < 30)
        begin
            waitTimeChange("minutes to reach 17", newTime);
            steps++;
        end
        checkValue("pause setup", 32'd17, 32'(currentTime.minutes));
        adj = 1'b0;
        // Bounce with highs of at most 3 cycles, shorter than the debounce
        // Even number of rising edges in all
        for (i = 0; i < 5; i++)
        begin
            btn1_val = 1'b1;
            repeat (1 + ({$random(seed)} % 3)) @(negedge adjclk);
            btn1_val = 1'b0;
            @(negedge adjclk);
        end
        btn1_val = 1'b1;
        // Quiet for 20 cycles means paused, a running count steps every 8
        stableRun = 0;
        cycles = 0;
        lastTime = currentTime;
        while (stableRun < 20 && cycles < 200)
        begin
            @(negedge adjclk);
            cycles++;
            stableRun = (currentTime == lastTime) ? stableRun + 1 : 0;
            lastTime = currentTime;
        end
        if (stableRun < 20)
        begin
            reportTimeout("the time to stop after a pause press");
        end
        adj = 1'b1;
        sel = 1'b1;
        repeat (50)
        begin
            @(negedge adjclk);
            checkValue("pause hold", 32'(lastTime), 32'(currentTime));
        end
        adj = 1'b0;
        sel = 1'b0;
        btn1_val = 1'b0;
        // Release must not toggle anything
        repeat (20)
        begin
            @(negedge adjclk);
            checkValue("pause release", 32'(lastTime), 32'(currentTime));
        end
    endtask

    task automatic testDisplay();
        timeValue heldTime;
        logic [3:0] lastAnodes;
        int prevPos;
        int pos;
        int digit;
        int cycles;
        heldTime = currentTime;
        prevPos = lowAnode(anodes);
        repeat (8)
        begin
            lastAnodes = anodes;
            cycles = 0;
            @(negedge adjclk);
            while (anodes == lastAnodes && cycles < changeLimit)
            begin
                @(negedge adjclk);
                cycles++;
            end
            if (anodes == lastAnodes)
            begin
                reportTimeout("the next display scan step");
            end
            pos = lowAnode(anodes);
            checkValue("display one anode", 32'd1, 32'(pos >= 0));
            checkValue("display order", 32'((prevPos + 1) % digitCount), 32'(pos));
            // secOnes, secTens, minOnes, minTens
            case (pos)
                0:       digit = int'(heldTime.seconds) % 10;
                1:       digit = int'(heldTime.seconds) / 10;
                2:       digit = int'(heldTime.minutes) % 10;
                default: digit = int'(heldTime.minutes) / 10;
            endcase
            checkValue("display segments", 32'(segmentTable[digit]), 32'(segments));
            checkValue("display time", 32'(heldTime), 32'(currentTime));
            prevPos = pos;
        end
    endtask

    task automatic testResume();
        timeValue prevTime;
        timeValue newTime;
        prevTime = currentTime;
        btn1_val = 1'b1;
        waitTimeChange("counting to resume", newTime);
        checkValue("resume", 32'(countNext(prevTime)), 32'(newTime));
        btn1_val = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////
    initial
    begin
        seed     = 73070;
        btn0_val = 1'b1;
        btn1_val = 1'b0;
        adj      = 1'b0;
        sel      = 1'b0;
        applyReset();
        testReset();
        testCounting();
        testAdjust();
        testMinuteWrap();
        testPause();
        testDisplay();
        testResume();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
